/* hw/CorePkg.sv */
// Core machine definitions
package CorePkg;

    localparam int Xlen = 64;

    typedef logic [31:0] instWord_t;
    typedef logic [4:0] regIndex_t;

    // bit positions of the instruction fields we decode.
    localparam int OpcodeLsb = 0;
    localparam int RdLsb = 7;
    localparam int Funct3Lsb = 12;
    localparam int ImmULsb = 12;
    localparam int ImmILsb = 20;
    localparam int Funct7Lsb = 25;

    // major opcodes of the arithmetic forms.
    localparam logic [6:0] OpcodeOp = 7'b0110011;
    localparam logic [6:0] OpcodeOpImm = 7'b0010011;
    localparam logic [6:0] OpcodeOp32 = 7'b0111011;
    localparam logic [6:0] OpcodeOpImm32 = 7'b0011011;
    localparam logic [6:0] OpcodeLui = 7'b0110111;

    // issue queue entry, instruction plus both register operands.
    typedef struct packed {
        instWord_t inst;
        logic [Xlen-1:0] rs1Value;
        logic [Xlen-1:0] rs2Value;
    } issueEntry_t;

    // result queue entry.
    typedef struct packed {
        regIndex_t rd;
        logic [Xlen-1:0] value;
        logic illegal;
    } resultEntry_t;

    // enough for depths up to 16.
    typedef logic [4:0] creditCount_t;

endpackage

/* hw/AluPkg.sv */
// ALU operation encodings
package AluPkg;

    typedef logic [4:0] aluOp_t;

    // bit 4 marks the 32-bit word forms.
    localparam aluOp_t AluAdd = 5'b00000;
    localparam aluOp_t AluAddW = 5'b10000;
    localparam aluOp_t AluSll = 5'b00001;
    localparam aluOp_t AluSllW = 5'b10001;
    localparam aluOp_t AluSlt = 5'b00010;
    localparam aluOp_t AluSltu = 5'b00011;
    localparam aluOp_t AluXor = 5'b00100;
    localparam aluOp_t AluSrl = 5'b00101;
    localparam aluOp_t AluSrlW = 5'b10101;
    localparam aluOp_t AluOr = 5'b00110;
    localparam aluOp_t AluAnd = 5'b00111;
    localparam aluOp_t AluSub = 5'b01000;
    localparam aluOp_t AluSubW = 5'b11000;
    localparam aluOp_t AluSra = 5'b01101;
    localparam aluOp_t AluSraW = 5'b11101;
    localparam aluOp_t AluPassB = 5'b01111;

    typedef logic [2:0] aluSel_t;

    // result multiplexer inputs.
    localparam aluSel_t SelAdder = 3'd0;
    localparam aluSel_t SelAnd = 3'd1;
    localparam aluSel_t SelOr = 3'd2;
    localparam aluSel_t SelXor = 3'd3;
    localparam aluSel_t SelShift = 3'd4;
    localparam aluSel_t SelPassB = 3'd5;
    localparam aluSel_t SelCompare = 3'd6;

endpackage

/* hw/AluControl.sv */
// ALU control decode
module AluControl (
    input  AluPkg::aluOp_t  aluOp,
    output logic            subtract,
    output logic            signedCompare,
    output logic            arithmetic,
    output logic            shiftRight,
    output logic            word,
    output AluPkg::aluSel_t select
);
    import AluPkg::*;

    always_comb begin
        // unknown codes fall back to a plain add.
        subtract = 1'b0;
        signedCompare = 1'b0;
        arithmetic = 1'b0;
        shiftRight = 1'b0;
        word = aluOp[4];
        select = SelAdder;
        case (aluOp)
            AluAdd, AluAddW: select = SelAdder;
            AluSub, AluSubW: begin
                subtract = 1'b1;
                select = SelAdder;
            end
            AluSll, AluSllW: select = SelShift;
            AluSrl, AluSrlW: begin
                shiftRight = 1'b1;
                select = SelShift;
            end
            AluSra, AluSraW: begin
                shiftRight = 1'b1;
                arithmetic = 1'b1;
                select = SelShift;
            end
            AluSlt: begin
                subtract = 1'b1;
                signedCompare = 1'b1;
                select = SelCompare;
            end
            AluSltu: begin
                subtract = 1'b1;
                select = SelCompare;
            end
            AluXor: select = SelXor;
            AluOr: select = SelOr;
            AluAnd: select = SelAnd;
            AluPassB: select = SelPassB;
            default: word = 1'b0;
        endcase
    end

endmodule

/* hw/Adder64.sv */
// 64-bit adder with flags
module Adder64 (
    input  logic [63:0] a,
    input  logic [63:0] b,
    input  logic        subtract,
    output logic [63:0] sum,
    output logic        carry,
    output logic        overflow,
    output logic        sign,
    output logic        zero
);

    logic [63:0] addend;

    // two's complement subtract, invert b and carry in one.
    assign addend = b ^ {64{subtract}};
    assign {carry, sum} = {1'b0, a} + {1'b0, addend} + {64'd0, subtract};

    // operands agree in sign but the sum does not.
    assign overflow = (a[63] == addend[63]) && (sum[63] != a[63]);
    assign sign = sum[63];
    assign zero = (sum == 64'd0);

endmodule

/* hw/Alu.sv */
// 64-bit integer ALU
module Alu (
    input  logic [CorePkg::Xlen-1:0] operandA,
    input  logic [CorePkg::Xlen-1:0] operandB,
    input  AluPkg::aluOp_t           aluOp,
    output logic [CorePkg::Xlen-1:0] result
);
    import AluPkg::*;

    logic subtract, signedCompare, arithmetic, shiftRight, word;
    aluSel_t select;
    logic [63:0] sum;
    logic carry, overflow, sign;
    logic [63:0] adderResult, shiftResult;
    logic [5:0] shamt;
    logic [4:0] shamtW;
    logic [31:0] lower32, sllW, srlW, sraW;
    logic [63:0] sll, srl, sra;
    logic setLess;

    AluControl control (
        .aluOp(aluOp),
        .subtract(subtract),
        .signedCompare(signedCompare),
        .arithmetic(arithmetic),
        .shiftRight(shiftRight),
        .word(word),
        .select(select)
    );

    Adder64 adder (
        .a(operandA),
        .b(operandB),
        .subtract(subtract),
        .sum(sum),
        .carry(carry),
        .overflow(overflow),
        .sign(sign),
        .zero()
    );

    assign adderResult = word ? {{32{sum[31]}}, sum[31:0]} : sum;

    // only the low bits of operand b count as a shift amount.
    assign shamt = operandB[5:0];
    assign shamtW = operandB[4:0];
    assign lower32 = operandA[31:0];

    assign sll = operandA << shamt;
    assign srl = operandA >> shamt;
    assign sra = $signed(operandA) >>> shamt;
    assign sllW = lower32 << shamtW;
    assign srlW = lower32 >> shamtW;
    assign sraW = $signed(lower32) >>> shamtW;

    always_comb begin
        if (!shiftRight) begin
            shiftResult = word ? {{32{sllW[31]}}, sllW} : sll;
        end else if (arithmetic) begin
            shiftResult = word ? {{32{sraW[31]}}, sraW} : sra;
        end else begin
            shiftResult = word ? {{32{srlW[31]}}, srlW} : srl;
        end
    end

    // a borrow clears the carry out on an unsigned subtract.
    assign setLess = signedCompare ? (overflow ^ sign) : ~carry;

    always_comb begin
        case (select)
            SelAdder: result = adderResult;
            SelAnd: result = operandA & operandB;
            SelOr: result = operandA | operandB;
            SelXor: result = operandA ^ operandB;
            SelShift: result = shiftResult;
            SelPassB: result = operandB;
            SelCompare: result = {63'd0, setLess};
            default: result = '0;
        endcase
    end

endmodule

/* hw/OpDecode.sv */
// Arithmetic instruction decode
module OpDecode (
    input  CorePkg::instWord_t       inst,
    input  logic [CorePkg::Xlen-1:0] rs1Value,
    input  logic [CorePkg::Xlen-1:0] rs2Value,
    output AluPkg::aluOp_t           aluOp,
    output logic [CorePkg::Xlen-1:0] operandA,
    output logic [CorePkg::Xlen-1:0] operandB,
    output CorePkg::regIndex_t       rd,
    output logic                     illegal
);
    import CorePkg::*;
    import AluPkg::*;

    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    logic [Xlen-1:0] immI, immU, shamt6, shamt5;

    assign opcode = inst[OpcodeLsb +: 7];
    assign funct3 = inst[Funct3Lsb +: 3];
    assign funct7 = inst[Funct7Lsb +: 7];
    assign rd = inst[RdLsb +: 5];

    assign immI = {{(Xlen - 12){inst[31]}}, inst[ImmILsb +: 12]};
    assign immU = {{(Xlen - 32){inst[31]}}, inst[ImmULsb +: 20], 12'd0};
    assign shamt6 = {{(Xlen - 6){1'b0}}, inst[ImmILsb +: 6]};
    assign shamt5 = {{(Xlen - 5){1'b0}}, inst[ImmILsb +: 5]};

    assign operandA = rs1Value;

    always_comb begin
        aluOp = AluAdd;
        operandB = rs2Value;
        illegal = 1'b0;
        case (opcode)
            OpcodeOp: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: aluOp = AluAdd;
                    {7'h20, 3'b000}: aluOp = AluSub;
                    {7'h00, 3'b001}: aluOp = AluSll;
                    {7'h00, 3'b010}: aluOp = AluSlt;
                    {7'h00, 3'b011}: aluOp = AluSltu;
                    {7'h00, 3'b100}: aluOp = AluXor;
                    {7'h00, 3'b101}: aluOp = AluSrl;
                    {7'h20, 3'b101}: aluOp = AluSra;
                    {7'h00, 3'b110}: aluOp = AluOr;
                    {7'h00, 3'b111}: aluOp = AluAnd;
                    default: illegal = 1'b1;
                endcase
            end
            OpcodeOpImm: begin
                operandB = immI;
                case (funct3)
                    3'b000: aluOp = AluAdd;
                    3'b010: aluOp = AluSlt;
                    3'b011: aluOp = AluSltu;
                    3'b100: aluOp = AluXor;
                    3'b110: aluOp = AluOr;
                    3'b111: aluOp = AluAnd;
                    default: begin
                        // 64-bit shifts take bit 25 as part of the amount.
                        operandB = shamt6;
                        case ({funct3, inst[31:26]})
                            {3'b001, 6'h00}: aluOp = AluSll;
                            {3'b101, 6'h00}: aluOp = AluSrl;
                            {3'b101, 6'h10}: aluOp = AluSra;
                            default: illegal = 1'b1;
                        endcase
                    end
                endcase
            end
            OpcodeOp32: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: aluOp = AluAddW;
                    {7'h20, 3'b000}: aluOp = AluSubW;
                    {7'h00, 3'b001}: aluOp = AluSllW;
                    {7'h00, 3'b101}: aluOp = AluSrlW;
                    {7'h20, 3'b101}: aluOp = AluSraW;
                    default: illegal = 1'b1;
                endcase
            end
            OpcodeOpImm32: begin
                operandB = (funct3 == 3'b000) ? immI : shamt5;
                case ({funct3, funct7})
                    {3'b001, 7'h00}: aluOp = AluSllW;
                    {3'b101, 7'h00}: aluOp = AluSrlW;
                    {3'b101, 7'h20}: aluOp = AluSraW;
                    default: begin
                        aluOp = AluAddW;
                        illegal = (funct3 != 3'b000);
                    end
                endcase
            end
            OpcodeLui: begin
                operandB = immU;
                aluOp = AluPassB;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* hw/CreditQueue.sv */
// Credit-returning FIFO
module CreditQueue #(
    parameter int Depth = 4,
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  payload_t pushData,
    input  logic     pop,
    output payload_t popData,
    output logic     notEmpty,
    output logic     full,
    output logic     credit
);

    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    payload_t storage [Depth];
    logic [PtrWidth-1:0] readPtr, writePtr;
    logic [CountWidth-1:0] count;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign popData = storage[readPtr];
    assign notEmpty = (count != '0);
    assign full = (count == CountWidth'(Depth));

    always_ff @(posedge clock) begin
        if (push) begin
            storage[writePtr] <= pushData;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
            credit <= 1'b0;
        end else begin
            // one credit back to the sender per freed slot.
            credit <= pop;
            if (push) writePtr <= nextPtr(writePtr);
            if (pop) readPtr <= nextPtr(readPtr);
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    // the producer must honor its credits.
    assert property (@(posedge clock) disable iff (reset) push |-> !full)
        else $error("push into a full queue");
    assert property (@(posedge clock) disable iff (reset) pop |-> notEmpty)
        else $error("pop from an empty queue");

endmodule

/* hw/ExecStage.sv */
// Execute pipeline register
module ExecStage (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  headValid,
    input  CorePkg::issueEntry_t  headEntry,
    output logic                  take,
    output logic                  outValid,
    output CorePkg::resultEntry_t outEntry,
    input  logic                  downstreamFull
);
    import CorePkg::*;
    import AluPkg::*;

    aluOp_t aluOp;
    logic [Xlen-1:0] operandA, operandB, aluResult;
    regIndex_t rd;
    logic illegal;
    logic handOff;

    OpDecode decode (
        .inst(headEntry.inst),
        .rs1Value(headEntry.rs1Value),
        .rs2Value(headEntry.rs2Value),
        .aluOp(aluOp),
        .operandA(operandA),
        .operandB(operandB),
        .rd(rd),
        .illegal(illegal)
    );

    Alu alu (
        .operandA(operandA),
        .operandB(operandB),
        .aluOp(aluOp),
        .result(aluResult)
    );

    assign handOff = outValid && !downstreamFull;
    assign take = headValid && (!outValid || handOff);

    always_ff @(posedge clock) begin
        if (reset) outValid <= 1'b0;
        else if (take) outValid <= 1'b1;
        else if (handOff) outValid <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (take) begin
            outEntry.rd <= rd;
            outEntry.value <= illegal ? '0 : aluResult;
            outEntry.illegal <= illegal;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        outValid && downstreamFull |=> outValid && $stable(outEntry))
        else $error("held result changed under back-pressure");

endmodule

/* hw/CreditSender.sv */
// Result credit sender
module CreditSender (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     resultCredit,
    input  logic                     queueNotEmpty,
    input  CorePkg::resultEntry_t    queueData,
    output logic                     pop,
    output logic                     resultValid,
    output CorePkg::regIndex_t       resultRd,
    output logic [CorePkg::Xlen-1:0] resultValue,
    output logic                     resultIllegal
);
    import CorePkg::*;

    creditCount_t credits;

    assign pop = queueNotEmpty && (credits != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= pop;
            if (resultCredit && !pop) credits <= credits + 1'b1;
            else if (pop && !resultCredit) credits <= credits - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            resultRd <= queueData.rd;
            resultValue <= queueData.value;
            resultIllegal <= queueData.illegal;
        end
    end

    assert property (@(posedge clock) disable iff (reset) resultValid |-> $past(credits) != '0)
        else $error("result sent without a credit");
    assert property (@(posedge clock) disable iff (reset)
        resultCredit && !pop |-> credits != '1)
        else $error("credit counter overflow");

endmodule

/* hw/ExecUnit.sv */
// Integer execute unit
module ExecUnit #(
    parameter int IssueDepth = 4,
    parameter int ResultDepth = 4
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     issueValid,
    input  CorePkg::instWord_t       issueInst,
    input  logic [CorePkg::Xlen-1:0] issueRs1Value,
    input  logic [CorePkg::Xlen-1:0] issueRs2Value,
    output logic                     issueCredit,
    input  logic                     resultCredit,
    output logic                     resultValid,
    output CorePkg::regIndex_t       resultRd,
    output logic [CorePkg::Xlen-1:0] resultValue,
    output logic                     resultIllegal
);
    import CorePkg::*;

    issueEntry_t issueEntry, issueHead;
    resultEntry_t stageEntry, resultHead;
    logic issueNotEmpty, stageTake, stageValid;
    logic resultNotEmpty, resultFull, resultPush, resultPop;

    assign issueEntry = '{inst: issueInst, rs1Value: issueRs1Value, rs2Value: issueRs2Value};
    assign resultPush = stageValid && !resultFull;

    CreditQueue #(.Depth(IssueDepth), .payload_t(issueEntry_t)) issueQueue (
        .clock(clock), .reset(reset),
        .push(issueValid), .pushData(issueEntry),
        .pop(stageTake), .popData(issueHead),
        .notEmpty(issueNotEmpty), .full(), .credit(issueCredit)
    );

    ExecStage stage (
        .clock(clock), .reset(reset),
        .headValid(issueNotEmpty), .headEntry(issueHead), .take(stageTake),
        .outValid(stageValid), .outEntry(stageEntry), .downstreamFull(resultFull)
    );

    CreditQueue #(.Depth(ResultDepth), .payload_t(resultEntry_t)) resultQueue (
        .clock(clock), .reset(reset),
        .push(resultPush), .pushData(stageEntry),
        .pop(resultPop), .popData(resultHead),
        .notEmpty(resultNotEmpty), .full(resultFull), .credit()
    );

    CreditSender sender (
        .clock(clock), .reset(reset),
        .resultCredit(resultCredit), .queueNotEmpty(resultNotEmpty),
        .queueData(resultHead), .pop(resultPop),
        .resultValid(resultValid), .resultRd(resultRd),
        .resultValue(resultValue), .resultIllegal(resultIllegal)
    );

endmodule

/* test/ExecUnitTb.sv */
// Execute unit testbench
module ExecUnitTb;
    timeunit 1ns;
    timeprecision 1ps;
    import CorePkg::*;

    localparam int IssueDepth = 4;
    localparam int ResultDepth = 4;
    localparam int TotalInsts = 8 + 10 + 6 + 4 + 9 + 200;
    localparam int TimeoutCycles = TotalInsts * 20 + 200;

    logic clock, reset, issueValid, issueCredit, resultCredit;
    logic resultValid, resultIllegal;
    instWord_t issueInst;
    logic [Xlen-1:0] issueRs1Value, issueRs2Value, resultValue;
    regIndex_t resultRd;

    resultEntry_t expected[$];
    int upCredits, outstanding, received, creditPulses, cycles;
    int passCount, failCount;
    bit autoCredit, randomCredit, quiet;
    logic [31:0] rngState;

    ExecUnit #(.IssueDepth(IssueDepth), .ResultDepth(ResultDepth)) UUT (
        .clock(clock), .reset(reset),
        .issueValid(issueValid), .issueInst(issueInst),
        .issueRs1Value(issueRs1Value), .issueRs2Value(issueRs2Value),
        .issueCredit(issueCredit), .resultCredit(resultCredit),
        .resultValid(resultValid), .resultRd(resultRd),
        .resultValue(resultValue), .resultIllegal(resultIllegal)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic instWord_t encodeR(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] op, input regIndex_t rd);
        return {f7, 5'd2, 5'd1, f3, rd, op};
    endfunction

    function automatic instWord_t encodeI(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] op, input regIndex_t rd);
        return {imm, 5'd1, f3, rd, op};
    endfunction

    // RV64 integer semantics where alt picks sub or sra.
    function automatic logic [63:0] op64(input logic [2:0] f3, input logic alt,
                                         input logic [63:0] a, input logic [63:0] b);
        logic signed [63:0] s;
        s = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'd0, s < $signed(b)};
            3'd3: return {63'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return s >>> b[5:0];
                else return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [63:0] op32(input logic [2:0] f3, input logic alt,
                                         input logic [63:0] a, input logic [63:0] b);
        logic signed [31:0] s;
        s = a[31:0];
        case (f3)
            3'd0: return alt ? sext32(a[31:0] - b[31:0]) : sext32(a[31:0] + b[31:0]);
            3'd1: return sext32(a[31:0] << b[4:0]);
            3'd5: begin
                if (alt) return sext32(s >>> b[4:0]);
                else return sext32(a[31:0] >> b[4:0]);
            end
            default: return '0;
        endcase
    endfunction

    task automatic model(input instWord_t inst, input logic [63:0] a, input logic [63:0] b,
                         output resultEntry_t res);
        logic [63:0] imm, v;
        logic [6:0] f7;
        logic [2:0] f3;
        logic bad;
        f7 = inst[31:25];
        f3 = inst[14:12];
        imm = {{52{inst[31]}}, inst[31:20]};
        v = '0;
        bad = 1'b0;
        case (inst[6:0])
            OpcodeOp: begin
                bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                v = op64(f3, inst[30], a, b);
            end
            OpcodeOpImm: begin
                if (f3 == 3'd1) bad = inst[31:26] != 6'h00;
                else if (f3 == 3'd5) bad = inst[31:26] != 6'h00 && inst[31:26] != 6'h10;
                v = op64(f3, (f3 == 3'd5) && inst[30], a, imm);
            end
            OpcodeOp32: begin
                bad = !((f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5))
                        || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                v = op32(f3, inst[30], a, b);
            end
            OpcodeOpImm32: begin
                if (f3 == 3'd0) begin
                    v = op32(3'd0, 1'b0, a, imm);
                end else begin
                    bad = !((f3 == 3'd1 && f7 == 7'h00)
                            || (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20)));
                    v = op32(f3, inst[30], a, imm);
                end
            end
            OpcodeLui: v = sext32({inst[31:12], 12'd0});
            default: bad = 1'b1;
        endcase
        res.rd = inst[11:7];
        res.illegal = bad;
        res.value = bad ? '0 : v;
    endtask

    task automatic checkValue(input logic [Xlen-1:0] actual, input logic [Xlen-1:0] exp,
                              input int index);
        if (actual !== exp) begin
            $display("ERR %0t: result %0d value 0x%h, expected 0x%h", $time, index, actual, exp);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic checkRd(input regIndex_t actual, input regIndex_t exp, input int index);
        if (actual !== exp) begin
            $display("ERR %0t: result %0d rd %0d, expected %0d", $time, index, actual, exp);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic checkIllegal(input logic actual, input logic exp, input int index);
        if (actual !== exp) begin
            $display("ERR %0t: result %0d illegal %b, expected %b", $time, index, actual, exp);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    // outputs are registered on the rising edge, so look at them on the falling one.
    always @(negedge clock) begin : monitor
        resultEntry_t exp;
        if (!reset) begin
            if (issueCredit) begin
                upCredits++;
                creditPulses++;
            end
            if (resultValid) begin
                outstanding--;
                received++;
                if (quiet) begin
                    $display("a result came out while no result credit had been granted");
                    failCount++;
                end
                if (expected.size() == 0) begin
                    $display("a result came out when none was expected");
                    failCount++;
                end else begin
                    exp = expected.pop_front();
                    checkRd(resultRd, exp.rd, received);
                    checkValue(resultValue, exp.value, received);
                    checkIllegal(resultIllegal, exp.illegal, received);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > TimeoutCycles) begin
            $display("timeout, the run went past %0d cycles", TimeoutCycles);
            $display("Test failed");
            $finish;
        end
    end

    // downstream grants only credits it can back with a pending result.
    task automatic stepCycle();
        if (autoCredit) begin
            resultCredit = (outstanding < expected.size()) && (outstanding < 8);
            if (randomCredit && nextRandom() % 3 == 0) resultCredit = 1'b0;
            if (resultCredit) outstanding++;
        end
        @(posedge clock);
        #2;
    endtask

    task automatic sendInst(input instWord_t inst, input logic [63:0] a, input logic [63:0] b);
        resultEntry_t res;
        while (upCredits == 0) stepCycle();
        model(inst, a, b, res);
        expected.push_back(res);
        issueValid = 1'b1;
        issueInst = inst;
        issueRs1Value = a;
        issueRs2Value = b;
        upCredits--;
        stepCycle();
        issueValid = 1'b0;
    endtask

    task automatic finishTest(input string name);
        while (expected.size() != 0 || upCredits != IssueDepth) stepCycle();
        $display("%s done, %0d failures so far", name, failCount);
    endtask

    task automatic runRegRegTest();
        logic [63:0] a, b;
        a = 64'hF0F0_1234_8765_ABCD;
        b = 64'h0F0F_9876_0000_0023;
        sendInst(encodeR(7'h00, 3'd0, OpcodeOp, 5'd1), a, b);
        sendInst(encodeR(7'h20, 3'd0, OpcodeOp, 5'd2), a, b);
        sendInst(encodeR(7'h00, 3'd7, OpcodeOp, 5'd3), a, b);
        sendInst(encodeR(7'h00, 3'd6, OpcodeOp, 5'd4), a, b);
        sendInst(encodeR(7'h00, 3'd4, OpcodeOp, 5'd5), a, b);
        sendInst(encodeR(7'h00, 3'd1, OpcodeOp, 5'd6), a, b);
        sendInst(encodeR(7'h00, 3'd5, OpcodeOp, 5'd7), a, b);
        sendInst(encodeR(7'h20, 3'd5, OpcodeOp, 5'd8), a, b);
        finishTest("register-register");
    endtask

    task automatic runWordTest();
        logic [63:0] a, b;
        a = 64'h1234_5678_8000_00F0;
        b = 64'hFFFF_FFFF_0000_0024;
        sendInst(encodeR(7'h00, 3'd0, OpcodeOp32, 5'd9), 64'h0000_0000_7FFF_FFFF, 64'd1);
        sendInst(encodeR(7'h20, 3'd0, OpcodeOp32, 5'd10), a, b);
        sendInst(encodeR(7'h00, 3'd1, OpcodeOp32, 5'd11), a, b);
        sendInst(encodeR(7'h00, 3'd5, OpcodeOp32, 5'd12), a, b);
        sendInst(encodeR(7'h20, 3'd5, OpcodeOp32, 5'd13), a, b);
        sendInst(encodeI(12'hFFF, 3'd0, OpcodeOpImm32, 5'd14), 64'h0000_0000_7FFF_FFFF, b);
        sendInst(encodeI({7'h00, 5'd31}, 3'd1, OpcodeOpImm32, 5'd15), 64'd3, b);
        sendInst(encodeI({7'h20, 5'd4}, 3'd5, OpcodeOpImm32, 5'd16), a, b);
        // the 64-bit immediate shifts reach past bit 31.
        sendInst(encodeI({6'h00, 6'd40}, 3'd1, OpcodeOpImm, 5'd17), a, b);
        sendInst(encodeI({6'h10, 6'd33}, 3'd5, OpcodeOpImm, 5'd18), 64'h8000_0000_0000_0000, b);
        finishTest("word forms");
    endtask

    task automatic runCompareTest();
        logic [63:0] a, b;
        a = 64'h8000_0000_0000_0001;
        b = 64'h0000_0000_0000_0001;
        sendInst(encodeR(7'h00, 3'd2, OpcodeOp, 5'd19), a, b);
        sendInst(encodeR(7'h00, 3'd3, OpcodeOp, 5'd20), a, b);
        sendInst(encodeR(7'h00, 3'd2, OpcodeOp, 5'd21), b, a);
        sendInst(encodeR(7'h00, 3'd3, OpcodeOp, 5'd22), b, a);
        sendInst(encodeI(12'hFFF, 3'd2, OpcodeOpImm, 5'd23), 64'h7FFF_FFFF_FFFF_FFFF, b);
        sendInst(encodeI(12'hFFF, 3'd3, OpcodeOpImm, 5'd24), 64'h7FFF_FFFF_FFFF_FFFF, b);
        finishTest("compare");
    endtask

    task automatic runLuiIllegalTest();
        sendInst({20'h80001, 5'd25, OpcodeLui}, 64'd0, 64'd0);
        sendInst({20'h12345, 5'd26, OpcodeLui}, 64'd0, 64'd0);
        sendInst({25'h1ABCDEF, 7'h7F}, 64'd5, 64'd6);
        // a multiply is outside this unit.
        sendInst(encodeR(7'h01, 3'd0, OpcodeOp, 5'd27), 64'd5, 64'd6);
        finishTest("lui and illegal");
    endtask

    task automatic runBackPressureTest();
        int issued, idle, receivedBefore, pulsesStart;
        logic [31:0] r;
        issued = 0;
        idle = 0;
        autoCredit = 1'b0;
        resultCredit = 1'b0;
        quiet = 1'b1;
        pulsesStart = creditPulses;
        while (idle < 10) begin
            if (upCredits > 0) begin
                r = nextRandom();
                sendInst(encodeI(r[11:0], 3'd0, OpcodeOpImm, r[16:12]), {r, nextRandom()}, 64'd0);
                issued++;
                idle = 0;
            end else begin
                stepCycle();
                idle++;
            end
        end
        quiet = 1'b0;
        if (issued != IssueDepth + ResultDepth + 1) begin
            $display("the unit accepted %0d instructions without result credits instead of %0d",
                     issued, IssueDepth + ResultDepth + 1);
            failCount++;
        end
        repeat (issued) begin
            receivedBefore = received;
            resultCredit = 1'b1;
            outstanding++;
            stepCycle();
            resultCredit = 1'b0;
            while (received == receivedBefore) stepCycle();
            repeat (4) stepCycle();
            if (received != receivedBefore + 1) begin
                $display("one result credit released %0d results", received - receivedBefore);
                failCount++;
            end
        end
        autoCredit = 1'b1;
        finishTest("back-pressure");
        if (creditPulses - pulsesStart != issued) begin
            $display("issue credits returned %0d times for %0d instructions",
                     creditPulses - pulsesStart, issued);
            failCount++;
        end
    endtask

    task automatic runRandomTest();
        logic [31:0] r, s;
        logic [6:0] op;
        logic [63:0] a, b;
        instWord_t inst;
        randomCredit = 1'b1;
        repeat (200) begin
            r = nextRandom();
            s = nextRandom();
            a = {nextRandom(), nextRandom()};
            b = {nextRandom(), nextRandom()};
            case (r[2:0])
                3'd2: op = OpcodeOpImm;
                3'd3: op = OpcodeOp32;
                3'd4: op = OpcodeOpImm32;
                3'd5: op = OpcodeLui;
                3'd7: op = r[9:3];
                default: op = OpcodeOp;
            endcase
            inst = {s[31:7], op};
            // funct fields are mostly made legal and a quarter stay raw.
            if (r[12:11] != 2'b11) begin
                if (op == OpcodeOp || op == OpcodeOp32
                    || (op == OpcodeOpImm32 && inst[13:12] == 2'b01)) begin
                    inst[31:25] = {1'b0, r[10], 5'd0};
                end else if (op == OpcodeOpImm && inst[13:12] == 2'b01) begin
                    inst[31:26] = {1'b0, r[10], 4'd0};
                end
            end
            sendInst(inst, a, b);
        end
        randomCredit = 1'b0;
        finishTest("random mixed stream");
    endtask

    initial begin
        reset = 1'b1;
        issueValid = 1'b0;
        issueInst = '0;
        issueRs1Value = '0;
        issueRs2Value = '0;
        resultCredit = 1'b0;
        rngState = 32'h7190;
        upCredits = IssueDepth;
        outstanding = 0;
        received = 0;
        creditPulses = 0;
        cycles = 0;
        passCount = 0;
        failCount = 0;
        autoCredit = 1'b1;
        randomCredit = 1'b0;
        quiet = 1'b0;
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        runRegRegTest();
        runWordTest();
        runCompareTest();
        runLuiIllegalTest();
        runBackPressureTest();
        runRandomTest();
        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* files.f */
hw/CorePkg.sv
hw/AluPkg.sv
hw/AluControl.sv
hw/Adder64.sv
hw/Alu.sv
hw/OpDecode.sv
hw/CreditQueue.sv
hw/ExecStage.sv
hw/CreditSender.sv
hw/ExecUnit.sv
test/ExecUnitTb.sv
